//--- soc_pkg.sv
package soc_pkg;

    // master bus.
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // address map, top nibble of the byte address.
    typedef logic [3:0] region_t;

    localparam region_t REGION_RAM  = 4'h0;
    localparam region_t REGION_ROM  = 4'h1;
    localparam region_t REGION_GPIO = 4'h2;
    localparam region_t REGION_TICK = 4'h3;

    localparam bus_data_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // data RAM, word addressed from bits 9:2.
    localparam int RAM_WORDS = 256;
    localparam int RAM_WAIT  = 2;
    localparam int RAM_CNT_W = $clog2(RAM_WAIT + 1);

    typedef logic [7:0]           ram_index_t;
    typedef logic [RAM_CNT_W-1:0] ram_wait_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } ram_state_t;

    // boot ROM, word addressed from bits 7:2.
    localparam int ROM_WORDS = 64;

    typedef logic [5:0] rom_index_t;

    localparam logic [15:0] ROM_TAG = 16'hB007;

    // register offsets for the peripheral slaves.
    typedef logic [7:0] reg_offset_t;

    localparam reg_offset_t GPIO_OUT = 8'h00;
    localparam reg_offset_t GPIO_DIR = 8'h04;
    localparam reg_offset_t GPIO_IN  = 8'h08;

    localparam reg_offset_t TICK_COUNT    = 8'h00;
    localparam reg_offset_t TICK_PRESCALE = 8'h04;

endpackage

//--- bus_decoder.sv
module bus_decoder (
    input  logic                  bus_read_i,
    input  logic                  bus_write_i,
    input  soc_pkg::bus_addr_t    bus_addr_i,
    input  soc_pkg::bus_data_t    bus_wdata_i,
    output soc_pkg::bus_data_t    bus_rdata_o,
    output logic                  bus_stall_o,

    output logic                  ram_rd_o,
    output logic                  ram_wr_o,
    output soc_pkg::ram_index_t   ram_index_o,
    input  soc_pkg::bus_data_t    ram_rdata_i,
    input  logic                  ram_stall_i,

    output logic                  rom_rd_o,
    output soc_pkg::rom_index_t   rom_index_o,
    input  soc_pkg::bus_data_t    rom_rdata_i,
    input  logic                  rom_stall_i,

    output logic                  gpio_rd_o,
    output logic                  gpio_wr_o,
    output logic                  tick_rd_o,
    output logic                  tick_wr_o,
    output soc_pkg::reg_offset_t  reg_offset_o,
    output soc_pkg::bus_data_t    wdata_o,
    input  soc_pkg::bus_data_t    gpio_rdata_i,
    input  soc_pkg::bus_data_t    tick_rdata_i
);

    soc_pkg::region_t region;

    logic sel_ram;
    logic sel_rom;
    logic sel_gpio;
    logic sel_tick;

    assign region = bus_addr_i[31:28];

    assign sel_ram  = (region == soc_pkg::REGION_RAM);
    assign sel_rom  = (region == soc_pkg::REGION_ROM);
    assign sel_gpio = (region == soc_pkg::REGION_GPIO);
    assign sel_tick = (region == soc_pkg::REGION_TICK);

    // slave strobes, at most one of them is high.
    assign ram_rd_o  = bus_read_i  & sel_ram;
    assign ram_wr_o  = bus_write_i & sel_ram;
    assign rom_rd_o  = bus_read_i  & sel_rom;
    assign gpio_rd_o = bus_read_i  & sel_gpio;
    assign gpio_wr_o = bus_write_i & sel_gpio;
    assign tick_rd_o = bus_read_i  & sel_tick;
    assign tick_wr_o = bus_write_i & sel_tick;

    // shared address and data fan-out.
    assign ram_index_o  = bus_addr_i[9:2];
    assign rom_index_o  = bus_addr_i[7:2];
    assign reg_offset_o = bus_addr_i[7:0];
    assign wdata_o      = bus_wdata_i;

    // return path from the selected slave.
    always_comb begin
        case (region)
            soc_pkg::REGION_RAM: begin
                bus_rdata_o = ram_rdata_i;
                bus_stall_o = ram_stall_i;
            end
            soc_pkg::REGION_ROM: begin
                bus_rdata_o = rom_rdata_i;
                bus_stall_o = rom_stall_i;
            end
            soc_pkg::REGION_GPIO: begin
                bus_rdata_o = gpio_rdata_i;
                bus_stall_o = 1'b0;
            end
            soc_pkg::REGION_TICK: begin
                bus_rdata_o = tick_rdata_i;
                bus_stall_o = 1'b0;
            end
            default: begin
                // nothing lives here, complete at once.
                bus_rdata_o = soc_pkg::UNMAPPED_DATA;
                bus_stall_o = 1'b0;
            end
        endcase
    end

endmodule

//--- data_ram.sv
module data_ram (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 rd_i,
    input  logic                 wr_i,
    input  soc_pkg::ram_index_t  index_i,
    input  soc_pkg::bus_data_t   wdata_i,
    output soc_pkg::bus_data_t   rdata_o,
    output logic                 stall_o
);

    soc_pkg::bus_data_t     mem [soc_pkg::RAM_WORDS];
    soc_pkg::bus_data_t     rdata_q;
    soc_pkg::ram_state_t    state_q;
    soc_pkg::ram_wait_cnt_t cnt_q;

    logic req;

    assign req = rd_i | wr_i;

    // the first strobe cycle counts as the first wait cycle.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= soc_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                soc_pkg::IDLE: begin
                    if (req) begin
                        cnt_q   <= soc_pkg::ram_wait_cnt_t'(1);
                        state_q <= (soc_pkg::RAM_WAIT > 1) ? soc_pkg::WAIT : soc_pkg::DONE;
                    end
                end
                soc_pkg::WAIT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == soc_pkg::ram_wait_cnt_t'(soc_pkg::RAM_WAIT - 1)) begin
                        state_q <= soc_pkg::DONE;
                    end
                end
                soc_pkg::DONE: begin
                    state_q <= soc_pkg::IDLE;
                end
                default: begin
                    state_q <= soc_pkg::IDLE;
                end
            endcase
        end
    end

    // index is held steady during the stall, so the word is ready by DONE.
    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_q <= mem[index_i];
        end
        if (wr_i && state_q == soc_pkg::DONE) begin
            mem[index_i] <= wdata_i;
        end
    end

    assign stall_o = req & (state_q != soc_pkg::DONE);
    assign rdata_o = rdata_q;

endmodule

//--- boot_rom.sv
module boot_rom (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 rd_i,
    input  soc_pkg::rom_index_t  index_i,
    output soc_pkg::bus_data_t   rdata_o,
    output logic                 stall_o
);

    soc_pkg::bus_data_t rom_table [soc_pkg::ROM_WORDS];
    soc_pkg::bus_data_t rdata_q;

    logic pending_q;

    // each word carries the tag above its own index.
    for (genvar i = 0; i < soc_pkg::ROM_WORDS; i++) begin : g_word
        assign rom_table[i] = {soc_pkg::ROM_TAG, 16'(i)};
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= rd_i & ~pending_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_q <= rom_table[index_i];
        end
    end

    assign stall_o = rd_i & ~pending_q;
    assign rdata_o = rdata_q;

endmodule

//--- gpio_ctl.sv
module gpio_ctl (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  soc_pkg::reg_offset_t  offset_i,
    input  soc_pkg::bus_data_t    wdata_i,
    output soc_pkg::bus_data_t    rdata_o,
    input  soc_pkg::bus_data_t    gpio_i,
    output soc_pkg::bus_data_t    gpio_o,
    output soc_pkg::bus_data_t    gpio_oe_o
);

    soc_pkg::bus_data_t out_q;
    soc_pkg::bus_data_t dir_q;
    soc_pkg::bus_data_t in_meta_q;
    soc_pkg::bus_data_t in_sync_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (wr_i) begin
            case (offset_i)
                soc_pkg::GPIO_OUT: out_q <= wdata_i;
                soc_pkg::GPIO_DIR: dir_q <= wdata_i;
                default: ;
            endcase
        end
    end

    // two flops before the pins reach the bus.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (offset_i)
                soc_pkg::GPIO_OUT: rdata_o = out_q;
                soc_pkg::GPIO_DIR: rdata_o = dir_q;
                soc_pkg::GPIO_IN:  rdata_o = in_sync_q;
                default:           rdata_o = '0;
            endcase
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

//--- tick_counter.sv
module tick_counter (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  soc_pkg::reg_offset_t  offset_i,
    input  soc_pkg::bus_data_t    wdata_i,
    output soc_pkg::bus_data_t    rdata_o
);

    soc_pkg::bus_data_t count_q;
    soc_pkg::bus_data_t prescale_q;
    soc_pkg::bus_data_t phase_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q    <= '0;
            prescale_q <= '0;
            phase_q    <= '0;
        end else begin
            if (wr_i && offset_i == soc_pkg::TICK_PRESCALE) begin
                prescale_q <= wdata_i;
            end
            // a count load also restarts the divider.
            if (wr_i && offset_i == soc_pkg::TICK_COUNT) begin
                count_q <= wdata_i;
                phase_q <= '0;
            end else if (phase_q >= prescale_q) begin
                count_q <= count_q + 1'b1;
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (offset_i)
                soc_pkg::TICK_COUNT:    rdata_o = count_q;
                soc_pkg::TICK_PRESCALE: rdata_o = prescale_q;
                default:                rdata_o = '0;
            endcase
        end
    end

endmodule

//--- soc_bus_top.sv
module soc_bus_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                bus_read_i,
    input  logic                bus_write_i,
    input  soc_pkg::bus_addr_t  bus_addr_i,
    input  soc_pkg::bus_data_t  bus_wdata_i,
    output soc_pkg::bus_data_t  bus_rdata_o,
    output logic                bus_stall_o,
    input  soc_pkg::bus_data_t  gpio_i,
    output soc_pkg::bus_data_t  gpio_o,
    output soc_pkg::bus_data_t  gpio_oe_o
);

    logic                  ram_rd;
    logic                  ram_wr;
    soc_pkg::ram_index_t   ram_index;
    soc_pkg::bus_data_t    ram_rdata;
    logic                  ram_stall;

    logic                  rom_rd;
    soc_pkg::rom_index_t   rom_index;
    soc_pkg::bus_data_t    rom_rdata;
    logic                  rom_stall;

    logic                  gpio_rd;
    logic                  gpio_wr;
    soc_pkg::bus_data_t    gpio_rdata;
    logic                  tick_rd;
    logic                  tick_wr;
    soc_pkg::bus_data_t    tick_rdata;

    soc_pkg::reg_offset_t  reg_offset;
    soc_pkg::bus_data_t    wdata;

    bus_decoder dbus0 (
        .bus_read_i   (bus_read_i),
        .bus_write_i  (bus_write_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .bus_rdata_o  (bus_rdata_o),
        .bus_stall_o  (bus_stall_o),
        .ram_rd_o     (ram_rd),
        .ram_wr_o     (ram_wr),
        .ram_index_o  (ram_index),
        .ram_rdata_i  (ram_rdata),
        .ram_stall_i  (ram_stall),
        .rom_rd_o     (rom_rd),
        .rom_index_o  (rom_index),
        .rom_rdata_i  (rom_rdata),
        .rom_stall_i  (rom_stall),
        .gpio_rd_o    (gpio_rd),
        .gpio_wr_o    (gpio_wr),
        .tick_rd_o    (tick_rd),
        .tick_wr_o    (tick_wr),
        .reg_offset_o (reg_offset),
        .wdata_o      (wdata),
        .gpio_rdata_i (gpio_rdata),
        .tick_rdata_i (tick_rdata)
    );

    data_ram ram0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .rd_i    (ram_rd),
        .wr_i    (ram_wr),
        .index_i (ram_index),
        .wdata_i (wdata),
        .rdata_o (ram_rdata),
        .stall_o (ram_stall)
    );

    boot_rom rom0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .rd_i    (rom_rd),
        .index_i (rom_index),
        .rdata_o (rom_rdata),
        .stall_o (rom_stall)
    );

    gpio_ctl gpio_inst (
        .clk       (clk),
        .rst_i     (rst_i),
        .rd_i      (gpio_rd),
        .wr_i      (gpio_wr),
        .offset_i  (reg_offset),
        .wdata_i   (wdata),
        .rdata_o   (gpio_rdata),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    tick_counter ticker_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .rd_i     (tick_rd),
        .wr_i     (tick_wr),
        .offset_i (reg_offset),
        .wdata_i  (wdata),
        .rdata_o  (tick_rdata)
    );

endmodule

//--- tb_checker.sv
module tb_checker #(
    parameter int NAME_CHARS = 20
) (
    input  logic                     clk,
    input  logic                     active_i,
    input  logic                     done_i,
    input  logic [8*NAME_CHARS-1:0]  name_i,
    input  logic [3:0]               check_i,
    input  soc_pkg::bus_data_t       expected_i,
    input  int                       stall_exp_i,
    input  logic                     bus_read_i,
    input  soc_pkg::bus_data_t       bus_rdata_i,
    input  logic                     bus_stall_i,
    input  soc_pkg::bus_data_t       gpio_out_i,
    input  soc_pkg::bus_data_t       gpio_oe_i,
    output int                       error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int tests = 0;
    int checked = 0;
    int errors = 0;
    int stall_seen = 0;

    logic entry_ok;
    logic reported = 1'b0;

    soc_pkg::bus_data_t last_rdata = '0;

    assign error_count_o = errors;

    task automatic report_mismatch(input string what, input soc_pkg::bus_data_t expected,
                                   input soc_pkg::bus_data_t actual);
        $display("FAILED %s %s expected %h, actual %h", name_i, what, expected, actual);
        errors++;
        entry_ok = 1'b0;
    endtask

    // bit 0 of check_i compares read data and bit 1 wants a change since the last read.
    // bit 2 compares gpio_o and bit 3 compares gpio_oe_o.
    always @(negedge clk) begin
        if (active_i && bus_stall_i) begin
            stall_seen++;
        end
        if (active_i && !bus_stall_i) begin
            tests++;
            entry_ok = 1'b1;
            if (stall_seen != stall_exp_i) begin
                $display("FAILED %s stall expected %0d cycles, actual %0d",
                         name_i, stall_exp_i, stall_seen);
                errors++;
                entry_ok = 1'b0;
            end
            stall_seen = 0;
            if (check_i[0] && bus_rdata_i !== expected_i) begin
                report_mismatch("rdata", expected_i, bus_rdata_i);
            end
            if (check_i[1] && bus_rdata_i === last_rdata) begin
                $display("FAILED %s rdata expected a change from %h, actual %h",
                         name_i, last_rdata, bus_rdata_i);
                errors++;
                entry_ok = 1'b0;
            end
            if (check_i[2] && gpio_out_i !== expected_i) begin
                report_mismatch("gpio_o", expected_i, gpio_out_i);
            end
            if (check_i[3] && gpio_oe_i !== expected_i) begin
                report_mismatch("gpio_oe_o", expected_i, gpio_oe_i);
            end
            if (check_i == 4'b0000) begin
                if (entry_ok) begin
                    $display("done   %s", name_i);
                end
            end else begin
                checked++;
                if (entry_ok) begin
                    $display("PASS   %s", name_i);
                end
            end
            if (bus_read_i) begin
                last_rdata = bus_rdata_i;
            end
        end
        if (done_i && !reported) begin
            reported = 1'b1;
            $display("%0d tests, %0d checked, %0d errors", tests, checked, errors);
        end
    end

endmodule

//--- tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int GPIO_SETTLE  = 2;
    localparam int MAX_ENTRIES  = 64;
    localparam int NAME_CHARS   = 20;

    localparam logic [31:0] LFSR_SEED = 32'h302a_5df0;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    localparam logic [1:0] OP_IDLE  = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;
    localparam logic [1:0] OP_PINS  = 2'd3;

    localparam logic [3:0] CHK_NONE  = 4'b0000;
    localparam logic [3:0] CHK_RDATA = 4'b0001;
    localparam logic [3:0] CHK_DIFF  = 4'b0010;
    localparam logic [3:0] CHK_OUT   = 4'b0100;
    localparam logic [3:0] CHK_OE    = 4'b1000;

    logic               clk;
    logic               rst_i;
    logic               bus_read_i;
    logic               bus_write_i;
    soc_pkg::bus_addr_t bus_addr_i;
    soc_pkg::bus_data_t bus_wdata_i;
    soc_pkg::bus_data_t bus_rdata_o;
    logic               bus_stall_o;
    soc_pkg::bus_data_t gpio_i;
    soc_pkg::bus_data_t gpio_o;
    soc_pkg::bus_data_t gpio_oe_o;

    // stimulus table with one row per test.
    logic [8*NAME_CHARS-1:0] tab_name  [MAX_ENTRIES];
    logic [1:0]              tab_op    [MAX_ENTRIES];
    soc_pkg::bus_addr_t      tab_addr  [MAX_ENTRIES];
    soc_pkg::bus_data_t      tab_wdata [MAX_ENTRIES];
    soc_pkg::bus_data_t      tab_exp   [MAX_ENTRIES];
    logic [3:0]              tab_check [MAX_ENTRIES];
    int                      n_entries = 0;

    logic [8*NAME_CHARS-1:0] cur_name;
    soc_pkg::bus_data_t      cur_exp;
    logic [3:0]              cur_check;
    int                      cur_stall;
    logic                    active;
    logic                    done;

    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          timeout_limit = 0;
    int          error_count;

    soc_bus_top UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus_read_i  (bus_read_i),
        .bus_write_i (bus_write_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_stall_o (bus_stall_o),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_oe_o   (gpio_oe_o)
    );

    tb_checker #(.NAME_CHARS(NAME_CHARS)) chk (
        .clk           (clk),
        .active_i      (active),
        .done_i        (done),
        .name_i        (cur_name),
        .check_i       (cur_check),
        .expected_i    (cur_exp),
        .stall_exp_i   (cur_stall),
        .bus_read_i    (bus_read_i),
        .bus_rdata_i   (bus_rdata_o),
        .bus_stall_i   (bus_stall_o),
        .gpio_out_i    (gpio_o),
        .gpio_oe_i     (gpio_oe_o),
        .error_count_o (error_count)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic take_random_word(output soc_pkg::bus_data_t word);
        int b;
        word = '0;
        for (b = 0; b < 32; b++) begin
            word = {word[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic soc_pkg::bus_addr_t ram_addr(input soc_pkg::ram_index_t idx);
        return {soc_pkg::REGION_RAM, 18'h0, idx, 2'b00};
    endfunction

    function automatic soc_pkg::bus_addr_t rom_addr(input soc_pkg::rom_index_t idx);
        return {soc_pkg::REGION_ROM, 20'h0, idx, 2'b00};
    endfunction

    function automatic soc_pkg::bus_addr_t reg_addr(input soc_pkg::region_t region,
                                                    input soc_pkg::reg_offset_t offset);
        return {region, 20'h0, offset};
    endfunction

    function automatic soc_pkg::bus_data_t rom_word(input soc_pkg::rom_index_t idx);
        return {soc_pkg::ROM_TAG, 10'h0, idx};
    endfunction

    // RAM accesses wait RAM_WAIT cycles and ROM reads wait one.
    function automatic int expected_stall(input logic [1:0] op, input soc_pkg::bus_addr_t addr);
        soc_pkg::region_t region;
        region = addr[31:28];
        if (op == OP_READ || op == OP_WRITE) begin
            if (region == soc_pkg::REGION_RAM) begin
                return soc_pkg::RAM_WAIT;
            end
            if (region == soc_pkg::REGION_ROM && op == OP_READ) begin
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic add_entry(input string name, input logic [1:0] op,
                             input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t wdata,
                             input soc_pkg::bus_data_t expected, input logic [3:0] check);
        logic [8*NAME_CHARS-1:0] padded;
        int i;
        // names are space padded so they print as a column.
        for (i = 0; i < NAME_CHARS; i++) begin
            padded[8*(NAME_CHARS-1-i) +: 8] = (i < name.len()) ? name[i] : " ";
        end
        tab_name[n_entries]  = padded;
        tab_op[n_entries]    = op;
        tab_addr[n_entries]  = addr;
        tab_wdata[n_entries] = wdata;
        tab_exp[n_entries]   = expected;
        tab_check[n_entries] = check;
        n_entries++;
    endtask

    task automatic build_table();
        soc_pkg::ram_index_t idx_list [5];
        soc_pkg::bus_data_t  ram_words [5];
        soc_pkg::rom_index_t rom_list [4];
        soc_pkg::bus_data_t  word;
        int k;
        int r;
        idx_list = '{8'd0, 8'd1, 8'd5, 8'd128, 8'd255};
        rom_list = '{6'd0, 6'd1, 6'd33, 6'd63};
        // back-to-back RAM writes followed by reads in the other order.
        for (k = 0; k < 5; k++) begin
            take_random_word(word);
            ram_words[k] = word;
            add_entry($sformatf("ram_wr_%0d", idx_list[k]), OP_WRITE, ram_addr(idx_list[k]),
                      word, word, CHK_NONE);
        end
        for (k = 4; k >= 0; k--) begin
            add_entry($sformatf("ram_rd_%0d", idx_list[k]), OP_READ, ram_addr(idx_list[k]),
                      '0, ram_words[k], CHK_RDATA);
        end
        take_random_word(word);
        add_entry("ram_wr_7", OP_WRITE, ram_addr(8'd7), word, word, CHK_NONE);
        add_entry("ram_rd_7", OP_READ, ram_addr(8'd7), '0, word, CHK_RDATA);
        for (k = 0; k < 4; k++) begin
            add_entry($sformatf("rom_rd_%0d", rom_list[k]), OP_READ, rom_addr(rom_list[k]),
                      '0, rom_word(rom_list[k]), CHK_RDATA);
        end
        add_entry("rom_wr_2", OP_WRITE, rom_addr(6'd2), 32'h1234_5678, 32'h1234_5678, CHK_NONE);
        add_entry("rom_rd_2", OP_READ, rom_addr(6'd2), '0, rom_word(6'd2), CHK_RDATA);
        add_entry("gpio_wr_out", OP_WRITE, reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT),
                  32'hC3A5_5A3C, 32'hC3A5_5A3C, CHK_NONE);
        add_entry("gpio_wr_dir", OP_WRITE, reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DIR),
                  32'h0000_FFFF, 32'h0000_FFFF, CHK_NONE);
        add_entry("gpio_rd_out", OP_READ, reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT),
                  '0, 32'hC3A5_5A3C, CHK_RDATA | CHK_OUT);
        add_entry("gpio_rd_dir", OP_READ, reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DIR),
                  '0, 32'h0000_FFFF, CHK_RDATA | CHK_OE);
        add_entry("gpio_pins", OP_PINS, '0, 32'h1357_9BDF, 32'h1357_9BDF, CHK_NONE);
        for (k = 0; k < GPIO_SETTLE; k++) begin
            add_entry("gpio_settle", OP_IDLE, '0, '0, '0, CHK_NONE);
        end
        add_entry("gpio_rd_in", OP_READ, reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN),
                  '0, 32'h1357_9BDF, CHK_RDATA);
        // with the largest prescale the loaded count holds still.
        add_entry("tick_wr_pre_max", OP_WRITE,
                  reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_PRESCALE),
                  32'hFFFF_FFFF, 32'hFFFF_FFFF, CHK_NONE);
        add_entry("tick_wr_count", OP_WRITE, reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_COUNT),
                  32'h1234_5678, 32'h1234_5678, CHK_NONE);
        add_entry("tick_rd_count", OP_READ, reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_COUNT),
                  '0, 32'h1234_5678, CHK_RDATA);
        add_entry("tick_rd_pre", OP_READ, reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_PRESCALE),
                  '0, 32'hFFFF_FFFF, CHK_RDATA);
        add_entry("tick_wr_pre_zero", OP_WRITE,
                  reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_PRESCALE), '0, '0, CHK_NONE);
        add_entry("tick_rd_first", OP_READ, reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_COUNT),
                  '0, '0, CHK_NONE);
        add_entry("tick_rd_second", OP_READ, reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_COUNT),
                  '0, '0, CHK_DIFF);
        for (r = 4; r < 16; r++) begin
            add_entry($sformatf("unmapped_rd_%0h", r), OP_READ, {r[3:0], 28'h000_0004},
                      '0, soc_pkg::UNMAPPED_DATA, CHK_RDATA);
        end
        // offset 4 aliases RAM word 1, GPIO_DIR and TICK_PRESCALE if decoded wrongly.
        add_entry("unmapped_wr", OP_WRITE, 32'h7000_0004, 32'hFFFF_FFFF, 32'hFFFF_FFFF, CHK_NONE);
        add_entry("after_wr_ram_1", OP_READ, ram_addr(8'd1), '0, ram_words[1], CHK_RDATA);
        add_entry("after_wr_rom_1", OP_READ, rom_addr(6'd1), '0, rom_word(6'd1), CHK_RDATA);
        add_entry("after_wr_gpio_dir", OP_READ,
                  reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DIR), '0, 32'h0000_FFFF, CHK_RDATA);
        add_entry("after_wr_tick_pre", OP_READ,
                  reg_addr(soc_pkg::REGION_TICK, soc_pkg::TICK_PRESCALE), '0, '0, CHK_RDATA);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int i;
        clk = 1'b0;
        lfsr_q = LFSR_SEED;
        rst_i <= 1'b1;
        bus_read_i <= 1'b0;
        bus_write_i <= 1'b0;
        bus_addr_i <= '0;
        bus_wdata_i <= '0;
        gpio_i <= '0;
        cur_name <= '0;
        cur_exp <= '0;
        cur_check <= CHK_NONE;
        cur_stall <= 0;
        active <= 1'b0;
        done <= 1'b0;
        build_table();
        timeout_limit = RESET_CYCLES + n_entries * (soc_pkg::RAM_WAIT + 4) + GPIO_SETTLE;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        for (i = 0; i < n_entries; i++) begin
            @(posedge clk);
            active <= 1'b1;
            cur_name <= tab_name[i];
            cur_exp <= tab_exp[i];
            cur_check <= tab_check[i];
            cur_stall <= expected_stall(tab_op[i], tab_addr[i]);
            bus_read_i <= (tab_op[i] == OP_READ);
            bus_write_i <= (tab_op[i] == OP_WRITE);
            bus_addr_i <= tab_addr[i];
            bus_wdata_i <= tab_wdata[i];
            if (tab_op[i] == OP_PINS) begin
                gpio_i <= tab_wdata[i];
            end
            // the request is held until the cycle where the stall is low.
            @(negedge clk);
            while (bus_stall_o) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        active <= 1'b0;
        bus_read_i <= 1'b0;
        bus_write_i <= 1'b0;
        done <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- project.f
soc_pkg.sv
bus_decoder.sv
data_ram.sv
boot_rom.sv
gpio_ctl.sv
tick_counter.sv
soc_bus_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_top -Mdir $(OBJ) -o sim

run: compile
	./$(OBJ)/sim | tee run.log
	@if grep -q '\*\* FAIL \*\*' run.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' run.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) run.log
